// File: Makefile
TOP       ?= cpu_tb
RTL_TOP   ?= cpu
SEED      ?= 1
LOG       ?= sim.log
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --x-assign unique --x-initial unique

RTL_SRCS := $(shell grep '^source/' $(FLIST))
ALL_SRCS := $(shell grep '\.s\?v$$' $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(ALL_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "No pass line found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb import rv_pkg::*; ();
    localparam word_t RESET_PC = 32'h0000_0000;
    localparam int    NT       = 5;     // Tests
    localparam int    NS       = 15;    // Expected stores over all tests
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;

    logic  clk, rst_n, mem_we;
    word_t im_addr, im_dout, mem_addr, mem_din, mem_dout;

    // Stores of test t start at exp_addr[store_first[t]]
    logic [5:0] prog_start  [NT] = '{6'd0, 6'd18, 6'd24, 6'd42, 6'd55};
    word_t      preload     [NT] = '{32'h0bad_0000, 32'h1234_5000, 32'h0bad_0002,
                                     32'h0bad_0003, 32'h0bad_0004};
    int         store_cnt   [NT] = '{5, 2, 3, 4, 1};
    int         store_first [NT] = '{0, 5, 7, 10, 14};
    word_t exp_addr [NS] = '{32'h40, 32'h44, 32'h48, 32'h4c, 32'h50, 32'h60, 32'h64,
                             32'h78, 32'h7c, 32'h80, 32'h90, 32'h94, 32'h98, 32'h9c, 32'ha0};
    word_t exp_data [NS] = '{32'h1e, 32'h1, 32'h0, 32'h0fff_fffd, 32'hc0, 32'h1234_5123,
                             32'h1234_5000, 32'h5, 32'hffff_ffff, 32'hffff_ffff, 32'h4,
                             32'h14, 32'habcd_e000, 32'h1024, 32'h0};

    word_t      imem [64];
    word_t      dmem [64] = '{default: '0};
    logic [5:0] wr_idx;
    logic [2:0] cur_test;
    int         seen, store_errs = 0, check_errs = 0, passed = 0, failed = 0;

    cpu #(.RESET_PC(RESET_PC)) cpu_i (
        .clk(clk), .rst_n(rst_n), .im_addr(im_addr), .im_dout(im_dout),
        .mem_addr(mem_addr), .mem_we(mem_we), .mem_din(mem_din), .mem_dout(mem_dout)
    );

    // Each program sees its own code from address zero
    assign im_dout  = imem[prog_start[cur_test] + im_addr[7:2]];
    assign mem_dout = dmem[mem_addr[7:2]];

    function automatic word_t r_type(input logic alt, input logic [2:0] f3,
                                     input int rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [6:0] op, input logic [2:0] f3,
                                     input int rd, rs1, imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic word_t s_type(input int rs2, rs1, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(input logic [2:0] f3, input int rs1, rs2, off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(input logic [6:0] op, input int rd, imm20);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic word_t j_type(input int rd, off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic word_t fill_word(input int idx);
        return 32'hc3c3_0000 ^ (idx * 32'h0004_0001);
    endfunction

    task automatic put(input word_t inst);
        imem[wr_idx] = inst;
        wr_idx = wr_idx + 6'd1;
    endtask

    task automatic build_image();
        for (int i = 0; i < 64; i++) begin
            imem[6'(i)] = i_type(OPC_IMM, 3'b000, 0, 0, i);   // addi x0, x0, i
        end
        wr_idx = '0;
        // ALU chain with MEM and WB forwarding
        put(i_type(OPC_IMM, 3'b000, 1, 0, 100));
        put(i_type(OPC_IMM, 3'b000, 2, 1, -30));
        put(r_type(1'b1, 3'b000, 3, 1, 2));
        put(s_type(3, 0, 'h40));
        put(i_type(OPC_IMM, 3'b000, 4, 0, -8));
        put(r_type(1'b0, 3'b010, 5, 4, 3));
        put(r_type(1'b0, 3'b011, 6, 4, 3));
        put(r_type(1'b1, 3'b101, 7, 4, 5));
        put(r_type(1'b0, 3'b001, 8, 3, 5));
        put(r_type(1'b0, 3'b100, 9, 7, 8));
        put(i_type(OPC_IMM, 3'b101, 10, 9, 4));
        put(r_type(1'b0, 3'b000, 11, 10, 5));
        put(i_type(OPC_IMM, 3'b111, 12, 9, 'hf0));
        put(s_type(5, 0, 'h44));
        put(s_type(6, 0, 'h48));
        put(s_type(11, 0, 'h4c));
        put(s_type(12, 0, 'h50));
        put(j_type(0, 0));
        // Load-use
        put(i_type(OPC_IMM, 3'b000, 3, 0, 'h123));
        put(i_type(OPC_LOAD, 3'b010, 1, 0, 0));
        put(r_type(1'b0, 3'b000, 2, 1, 3));
        put(s_type(2, 0, 'h60));
        put(s_type(1, 0, 'h64));
        put(j_type(0, 0));
        // Branches with silent slots after each taken one
        put(i_type(OPC_IMM, 3'b000, 1, 0, 5));
        put(i_type(OPC_IMM, 3'b000, 2, 0, -1));
        put(b_type(3'b000, 1, 1, 12));
        put(s_type(1, 0, 'h70));
        put(s_type(1, 0, 'h74));
        put(b_type(3'b100, 2, 1, 12));
        put(s_type(2, 0, 'h70));
        put(s_type(2, 0, 'h74));
        put(b_type(3'b110, 2, 1, 12));
        put(s_type(1, 0, 'h78));
        put(b_type(3'b000, 1, 2, 8));
        put(s_type(2, 0, 'h7c));
        put(b_type(3'b110, 1, 2, 12));
        put(s_type(0, 0, 'h70));
        put(s_type(0, 0, 'h74));
        put(b_type(3'b100, 1, 2, 8));
        put(s_type(2, 0, 'h80));
        put(j_type(0, 0));
        // Jumps, lui and auipc
        put(j_type(1, 8));
        put(s_type(0, 0, 'h90));
        put(s_type(1, 0, 'h90));
        put(i_type(OPC_IMM, 3'b000, 5, 0, 29));
        put(i_type(OPC_JALR, 3'b000, 6, 5, 0));
        put(s_type(0, 0, 'h94));
        put(s_type(0, 0, 'h94));
        put(s_type(6, 0, 'h94));
        put(u_type(OPC_LUI, 7, 'habcde));
        put(u_type(OPC_AUIPC, 8, 'h1));
        put(s_type(7, 0, 'h98));
        put(s_type(8, 0, 'h9c));
        put(j_type(0, 0));
        // Writes to x0
        put(i_type(OPC_IMM, 3'b000, 0, 0, 55));
        put(u_type(OPC_LUI, 0, 'h12345));
        put(s_type(0, 0, 'ha0));
        put(j_type(0, 0));
    endtask

    // Data memory model with the store monitor
    always @(posedge clk) begin : store_monitor
        int k;
        k = store_first[cur_test] + seen;
        if (!rst_n) begin                             // Refill and preload
            for (int i = 0; i < 64; i++) begin
                dmem[6'(i)] <= fill_word(i);
            end
            dmem[0] <= preload[cur_test];
            seen    <= 0;
        end else if (mem_we) begin
            dmem[mem_addr[7:2]] <= mem_din;
            if (seen >= store_cnt[cur_test]) begin
                $display("Fail %0t: test %0d extra store of %h to %h",
                         $time, cur_test, mem_din, mem_addr);
                store_errs = store_errs + 1;
            end else if (mem_addr !== exp_addr[4'(k)] || mem_din !== exp_data[4'(k)]) begin
                $display("Fail %0t: test %0d store %0d wrote %h to %h, expected %h to %h",
                         $time, cur_test, seen, mem_din, mem_addr,
                         exp_data[4'(k)], exp_addr[4'(k)]);
                store_errs = store_errs + 1;
            end
            seen <= seen + 1;
        end
    end

    task automatic run_test(input int t);
        int errs_before;
        errs_before = store_errs + check_errs;
        @(negedge clk);
        cur_test = 3'(t);
        rst_n    = 1'b0;
        repeat (10) @(negedge clk);
        if (im_addr !== RESET_PC) begin
            $display("Fail %0t: im_addr %h after reset, expected %h", $time, im_addr, RESET_PC);
            check_errs = check_errs + 1;
        end
        if (mem_we !== 1'b0) begin
            $display("Fail %0t: mem_we high during reset", $time);
            check_errs = check_errs + 1;
        end
        rst_n = 1'b1;
        while (seen < store_cnt[cur_test]) @(negedge clk);
        repeat (10) @(negedge clk);                  // Catch late extra stores
        if (store_errs + check_errs == errs_before) begin
            passed = passed + 1;
            $display("Test %0d passed with %0d stores", t, seen);
        end else begin
            failed = failed + 1;
            $display("Test %0d failed", t);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n    = 1'b0;
        cur_test = '0;
        build_image();
        for (int t = 0; t < NT; t++) begin
            run_test(t);
        end
        $display("Tests passed %0d, failed %0d", passed, failed);
        if (store_errs + check_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (200 * NT) @(posedge clk);
        $display("Timeout: test %0d never reached its expected store count", cur_test);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
source/rv_pkg.sv
source/decoder.sv
source/reg_file.sv
source/execute.sv
source/hazard_unit.sv
source/cpu.sv
bench/cpu_tb.sv

// File: source/cpu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_0000
) (
    input  wire        clk,
    input  wire        rst_n,
    output word_t      im_addr,
    input  wire word_t im_dout,
    output word_t      mem_addr,
    output logic       mem_we,
    output word_t      mem_din,
    input  wire word_t mem_dout
);
    word_t pc, pc_plus4, pc_next;

    logic  if_id_valid;
    word_t if_id_pc, if_id_inst;

    reg_addr_t dec_rs1, dec_rs2, dec_rd;
    logic      dec_rs1_used, dec_rs2_used, dec_reg_we, dec_mem_we;
    logic      dec_src1_pc, dec_src2_imm, dec_jal, dec_jalr;
    wb_sel_e   dec_wb_sel;
    alu_op_e   dec_alu_op;
    br_type_e  dec_br_type;
    word_t     dec_imm, rf_rd0, rf_rd1;

    logic      id_ex_valid, id_ex_reg_we, id_ex_mem_we, id_ex_jal, id_ex_jalr;
    br_type_e  id_ex_br_type;
    reg_addr_t id_ex_rs1, id_ex_rs2, id_ex_rd;
    logic      id_ex_rs1_used, id_ex_rs2_used, id_ex_src1_pc, id_ex_src2_imm;
    wb_sel_e   id_ex_wb_sel;
    alu_op_e   id_ex_alu_op;
    word_t     id_ex_pc, id_ex_pc4, id_ex_imm, id_ex_rs1_val, id_ex_rs2_val;

    word_t    rs1_fwd, rs2_fwd, alu_ans, target;
    logic     redirect, stall, flush, bubble_mem;
    logic     ex_jal, ex_jalr;
    br_type_e ex_br_type;

    logic      ex_mem_valid, ex_mem_reg_we, ex_mem_mem_we;
    reg_addr_t ex_mem_rd;
    wb_sel_e   ex_mem_wb_sel;
    word_t     ex_mem_alu_ans, ex_mem_pc4, ex_mem_imm, ex_mem_store;

    logic      mem_wb_valid, mem_wb_reg_we, wb_we;
    reg_addr_t mem_wb_rd;
    wb_sel_e   mem_wb_wb_sel;
    word_t     mem_wb_alu_ans, mem_wb_pc4, mem_wb_imm, mem_wb_dout, wb_data;

    assign pc_plus4 = pc + 32'd4;
    assign pc_next  = flush ? target : pc_plus4;
    assign im_addr  = pc;

    // Bubbles only drop the valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc            <= RESET_PC;
            if_id_valid   <= 1'b0;
            if_id_inst    <= NOP_INST;
            id_ex_valid   <= 1'b0;
            id_ex_reg_we  <= 1'b0;
            id_ex_mem_we  <= 1'b0;
            id_ex_jal     <= 1'b0;
            id_ex_jalr    <= 1'b0;
            id_ex_br_type <= BR_NONE;
            ex_mem_valid  <= 1'b0;
            ex_mem_reg_we <= 1'b0;
            ex_mem_mem_we <= 1'b0;
            mem_wb_valid  <= 1'b0;
            mem_wb_reg_we <= 1'b0;
        end else begin
            if (!stall) begin
                pc            <= pc_next;
                if_id_valid   <= !flush;
                if_id_inst    <= flush ? NOP_INST : im_dout;
                id_ex_valid   <= if_id_valid && !flush;
                id_ex_reg_we  <= dec_reg_we;
                id_ex_mem_we  <= dec_mem_we;
                id_ex_jal     <= dec_jal;
                id_ex_jalr    <= dec_jalr;
                id_ex_br_type <= dec_br_type;
            end
            ex_mem_valid  <= id_ex_valid && !bubble_mem;
            ex_mem_reg_we <= id_ex_reg_we;
            ex_mem_mem_we <= id_ex_mem_we;
            mem_wb_valid  <= ex_mem_valid;
            mem_wb_reg_we <= ex_mem_reg_we;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc       <= pc;
            id_ex_pc       <= if_id_pc;
            id_ex_pc4      <= if_id_pc + 32'd4;
            id_ex_rs1      <= dec_rs1;
            id_ex_rs2      <= dec_rs2;
            id_ex_rd       <= dec_rd;
            id_ex_rs1_used <= dec_rs1_used;
            id_ex_rs2_used <= dec_rs2_used;
            id_ex_wb_sel   <= dec_wb_sel;
            id_ex_imm      <= dec_imm;
            id_ex_alu_op   <= dec_alu_op;
            id_ex_src1_pc  <= dec_src1_pc;
            id_ex_src2_imm <= dec_src2_imm;
            id_ex_rs1_val  <= rf_rd0;
            id_ex_rs2_val  <= rf_rd1;
        end else begin
            id_ex_rs1_val  <= rs1_fwd;   // WB result leaves during the stall
            id_ex_rs2_val  <= rs2_fwd;
        end
        ex_mem_rd      <= id_ex_rd;
        ex_mem_wb_sel  <= id_ex_wb_sel;
        ex_mem_alu_ans <= alu_ans;
        ex_mem_pc4     <= id_ex_pc4;
        ex_mem_imm     <= id_ex_imm;
        ex_mem_store   <= rs2_fwd;
        mem_wb_rd      <= ex_mem_rd;
        mem_wb_wb_sel  <= ex_mem_wb_sel;
        mem_wb_alu_ans <= ex_mem_alu_ans;
        mem_wb_pc4     <= ex_mem_pc4;
        mem_wb_imm     <= ex_mem_imm;
        mem_wb_dout    <= mem_dout;      // Load data captured here
    end

    decoder decoder_i (
        .inst(if_id_inst), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .rs1_used(dec_rs1_used), .rs2_used(dec_rs2_used),
        .reg_we(dec_reg_we), .wb_sel(dec_wb_sel), .imm(dec_imm), .alu_op(dec_alu_op),
        .src1_pc(dec_src1_pc), .src2_imm(dec_src2_imm), .br_type(dec_br_type),
        .jal(dec_jal), .jalr(dec_jalr), .mem_we(dec_mem_we)
    );

    reg_file reg_file_i (
        .clk(clk), .rst_n(rst_n), .ra0(dec_rs1), .ra1(dec_rs2), .rd0(rf_rd0), .rd1(rf_rd1),
        .we(wb_we), .wa(mem_wb_rd), .wd(wb_data)
    );

    assign ex_jal     = id_ex_valid && id_ex_jal;
    assign ex_jalr    = id_ex_valid && id_ex_jalr;
    assign ex_br_type = id_ex_valid ? id_ex_br_type : BR_NONE;

    execute execute_i (
        .pc(id_ex_pc), .imm(id_ex_imm), .rs1_val(rs1_fwd), .rs2_val(rs2_fwd),
        .alu_op(id_ex_alu_op), .src1_pc(id_ex_src1_pc), .src2_imm(id_ex_src2_imm),
        .br_type(ex_br_type), .jal(ex_jal), .jalr(ex_jalr),
        .alu_ans(alu_ans), .redirect(redirect), .target(target)
    );

    hazard_unit hazard_unit_i (
        .rs1_ex(id_ex_rs1), .rs2_ex(id_ex_rs2),
        .rs1_used_ex(id_ex_valid && id_ex_rs1_used), .rs2_used_ex(id_ex_valid && id_ex_rs2_used),
        .rs1_raw(id_ex_rs1_val), .rs2_raw(id_ex_rs2_val),
        .rd_mem(ex_mem_rd), .we_mem(ex_mem_valid && ex_mem_reg_we), .wb_sel_mem(ex_mem_wb_sel),
        .alu_ans_mem(ex_mem_alu_ans), .pc4_mem(ex_mem_pc4), .imm_mem(ex_mem_imm),
        .rd_wb(mem_wb_rd), .we_wb(wb_we), .wd_wb(wb_data), .redirect(redirect),
        .rs1_fwd(rs1_fwd), .rs2_fwd(rs2_fwd), .stall(stall), .flush(flush),
        .bubble_mem(bubble_mem)
    );

    assign mem_addr = ex_mem_alu_ans;
    assign mem_din  = ex_mem_store;
    assign mem_we   = ex_mem_valid && ex_mem_mem_we;
    assign wb_we    = mem_wb_valid && mem_wb_reg_we;

    always_comb begin
        case (mem_wb_wb_sel)
            WB_PC4:  wb_data = mem_wb_pc4;
            WB_MEM:  wb_data = mem_wb_dout;
            WB_IMM:  wb_data = mem_wb_imm;
            default: wb_data = mem_wb_alu_ans;
        endcase
    end

endmodule

`default_nettype wire

// File: source/decoder.sv
`timescale 1ns/10ps
`default_nettype none

module decoder import rv_pkg::*; (
    input  wire word_t inst,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    output reg_addr_t  rd,
    output logic       rs1_used,
    output logic       rs2_used,
    output logic       reg_we,
    output wb_sel_e    wb_sel,
    output word_t      imm,
    output alu_op_e    alu_op,
    output logic       src1_pc,
    output logic       src2_imm,
    output br_type_e   br_type,
    output logic       jal,
    output logic       jalr,
    output logic       mem_we
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       writes_rd;
    alu_op_e    arith_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];
    assign reg_we = writes_rd && (rd != '0);

    // Shared by register and immediate forms, sub only exists for OP
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OP_OP && inst[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = inst[30] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        rs1_used  = 1'b0;
        rs2_used  = 1'b0;
        writes_rd = 1'b0;
        wb_sel    = WB_ALU;
        imm       = '0;
        alu_op    = ALU_ADD;
        src1_pc   = 1'b0;
        src2_imm  = 1'b0;
        br_type   = BR_NONE;
        jal       = 1'b0;
        jalr      = 1'b0;
        mem_we    = 1'b0;
        case (opcode)
            OP_OP: begin
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
                writes_rd = 1'b1;
                alu_op    = arith_op;
            end
            OP_OP_IMM: begin
                rs1_used  = 1'b1;
                writes_rd = 1'b1;
                imm       = {{20{inst[31]}}, inst[31:20]};
                alu_op    = arith_op;
                src2_imm  = 1'b1;
            end
            OP_LUI: begin
                writes_rd = 1'b1;
                wb_sel    = WB_IMM;
                imm       = {inst[31:12], 12'b0};
            end
            OP_AUIPC: begin
                writes_rd = 1'b1;
                imm       = {inst[31:12], 12'b0};
                src1_pc   = 1'b1;
                src2_imm  = 1'b1;
            end
            OP_LOAD: begin                            // lw only
                rs1_used  = 1'b1;
                writes_rd = 1'b1;
                wb_sel    = WB_MEM;
                imm       = {{20{inst[31]}}, inst[31:20]};
                src2_imm  = 1'b1;
            end
            OP_STORE: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                src2_imm = 1'b1;
                mem_we   = 1'b1;
            end
            OP_BRANCH: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                imm      = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                src1_pc  = 1'b1;                      // ALU gives the target
                src2_imm = 1'b1;
                case (funct3)
                    3'b000:  br_type = BR_EQ;
                    3'b100:  br_type = BR_LT;
                    3'b110:  br_type = BR_LTU;
                    default: br_type = BR_NONE;
                endcase
            end
            OP_JAL: begin
                writes_rd = 1'b1;
                wb_sel    = WB_PC4;
                imm       = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                src1_pc   = 1'b1;
                src2_imm  = 1'b1;
                jal       = 1'b1;
            end
            OP_JALR: begin
                rs1_used  = 1'b1;
                writes_rd = 1'b1;
                wb_sel    = WB_PC4;
                imm       = {{20{inst[31]}}, inst[31:20]};
                src2_imm  = 1'b1;
                jalr      = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute import rv_pkg::*; (
    input  wire word_t    pc,
    input  wire word_t    imm,
    input  wire word_t    rs1_val,
    input  wire word_t    rs2_val,
    input  wire alu_op_e  alu_op,
    input  wire           src1_pc,
    input  wire           src2_imm,
    input  wire br_type_e br_type,
    input  wire           jal,
    input  wire           jalr,
    output word_t         alu_ans,
    output logic          redirect,
    output word_t         target
);
    word_t src_a;
    word_t src_b;
    logic  taken;

    assign src_a = src1_pc ? pc : rs1_val;
    assign src_b = src2_imm ? imm : rs2_val;

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_ans = src_a - src_b;
            ALU_AND:  alu_ans = src_a & src_b;
            ALU_OR:   alu_ans = src_a | src_b;
            ALU_XOR:  alu_ans = src_a ^ src_b;
            ALU_SLT:  alu_ans = {31'b0, $signed(src_a) < $signed(src_b)};
            ALU_SLTU: alu_ans = {31'b0, src_a < src_b};
            ALU_SLL:  alu_ans = src_a << src_b[4:0];
            ALU_SRL:  alu_ans = src_a >> src_b[4:0];
            ALU_SRA:  alu_ans = $signed(src_a) >>> src_b[4:0];
            default:  alu_ans = src_a + src_b;
        endcase
    end

    // Compare the register operands, the ALU is busy with pc + imm
    always_comb begin
        case (br_type)
            BR_EQ:   taken = (rs1_val == rs2_val);
            BR_LT:   taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_LTU:  taken = (rs1_val < rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign redirect = taken || jal || jalr;
    assign target   = jalr ? {alu_ans[31:1], 1'b0} : alu_ans;

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit import rv_pkg::*; (
    input  wire reg_addr_t rs1_ex,
    input  wire reg_addr_t rs2_ex,
    input  wire            rs1_used_ex,
    input  wire            rs2_used_ex,
    input  wire word_t     rs1_raw,
    input  wire word_t     rs2_raw,
    input  wire reg_addr_t rd_mem,
    input  wire            we_mem,
    input  wire wb_sel_e   wb_sel_mem,
    input  wire word_t     alu_ans_mem,
    input  wire word_t     pc4_mem,
    input  wire word_t     imm_mem,
    input  wire reg_addr_t rd_wb,
    input  wire            we_wb,
    input  wire word_t     wd_wb,
    input  wire            redirect,
    output word_t          rs1_fwd,
    output word_t          rs2_fwd,
    output logic           stall,
    output logic           flush,
    output logic           bubble_mem
);
    word_t mem_val;
    logic  load_use;

    // Load data is not ready in MEM, that case stalls instead
    always_comb begin
        case (wb_sel_mem)
            WB_PC4:  mem_val = pc4_mem;
            WB_IMM:  mem_val = imm_mem;
            default: mem_val = alu_ans_mem;
        endcase
    end

    function automatic word_t fwd_operand(reg_addr_t src, logic used, word_t raw);
        if (used && src != '0 && we_mem && src == rd_mem) begin
            return mem_val;                       // MEM is younger
        end else if (used && src != '0 && we_wb && src == rd_wb) begin
            return wd_wb;
        end
        return raw;
    endfunction

    always_comb begin
        rs1_fwd = fwd_operand(rs1_ex, rs1_used_ex, rs1_raw);
        rs2_fwd = fwd_operand(rs2_ex, rs2_used_ex, rs2_raw);
    end

    assign load_use = we_mem && wb_sel_mem == WB_MEM && rd_mem != '0 &&
                      ((rs1_used_ex && rs1_ex == rd_mem) || (rs2_used_ex && rs2_ex == rd_mem));

    assign stall      = load_use;
    assign bubble_mem = load_use;
    assign flush      = redirect && !load_use;   // Operands stale while stalled

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import rv_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire reg_addr_t ra0,
    input  wire reg_addr_t ra1,
    output word_t          rd0,
    output word_t          rd1,
    input  wire            we,
    input  wire reg_addr_t wa,
    input  wire word_t     wd
);
    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin   // x0 never written
            regs[wa] <= wd;
        end
    end

    // Write-through, ID sees the WB result in the same cycle
    assign rd0 = (ra0 == '0) ? '0 : (we && wa == ra0) ? wd : regs[ra0];
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];

endmodule

`default_nettype wire

// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;     // Data, address or instruction
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // Register write data source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_PC4,
        WB_MEM,
        WB_IMM
    } wb_sel_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_LT,
        BR_LTU
    } br_type_e;

    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    localparam word_t NOP_INST = 32'h0000_0033; // add x0, x0, x0

endpackage

`default_nettype wire
